//--- src/core_pkg.sv
package core_pkg;

	// Decoded operations carried from decode to write-back
	typedef enum logic [3:0] {
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_ILLEGAL
	} op_e;

	// Major opcode field, instruction bits 6:0
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	localparam logic [31:0] RESET_PC   = 32'h8000_0000;
	localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
	// mtime low sits at offset 0 and high at offset 4
	localparam logic [31:0] CLINT_MASK = 32'hffff_fff8;
	localparam int          REG_COUNT  = 16;

endpackage

//--- src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic        clock,
	input  logic        rst,
	input  logic [3:0]  raddr1,
	input  logic [3:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic [3:0]  waddr,
	input  logic [31:0] wdata,
	input  logic        wen
);

	logic [31:0] regs [core_pkg::REG_COUNT];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < core_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wen) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero whatever was written to it
	assign rdata1 = raddr1 == 4'd0 ? 32'd0 : regs[raddr1];
	assign rdata2 = raddr2 == 4'd0 ? 32'd0 : regs[raddr2];

endmodule

//--- src/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
	input  logic            clock,
	input  logic            rst,
	input  logic            tm_arvalid,
	output logic            tm_arready,
	input  logic [31:0]     tm_araddr,
	output logic            tm_rvalid,
	input  logic            tm_rready,
	output logic [31:0]     tm_rdata,
	output core_pkg::resp_e tm_rresp
);

	logic [63:0] mtime;

	always_ff @(posedge clock) begin
		if (rst) begin
			mtime      <= 64'd0;
			tm_arready <= 1'b0;
			tm_rvalid  <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (tm_arvalid && tm_arready) begin
				tm_arready <= 1'b0;
				tm_rvalid  <= 1'b1;
				// Bit 2 picks the half
				tm_rdata   <= tm_araddr[2] ? mtime[63:32] : mtime[31:0];
				// A misaligned offset gets an error
				tm_rresp   <= tm_araddr[1:0] == 2'b00 ?
					core_pkg::RESP_OKAY : core_pkg::RESP_SLVERR;
			end else if (tm_rvalid && tm_rready) begin
				tm_rvalid  <= 1'b0;
				tm_arready <= 1'b1;
			end else if (!tm_rvalid) begin
				tm_arready <= 1'b1;
			end
		end
	end

endmodule

//--- src/bus_xbar.sv
`timescale 1ns/1ns

module bus_xbar (
	input  logic            clock,
	input  logic            rst,
	input  logic            if_arvalid,
	output logic            if_arready,
	input  logic [31:0]     if_araddr,
	output logic            if_rvalid,
	input  logic            if_rready,
	output logic [31:0]     if_rdata,
	input  logic            ls_arvalid,
	output logic            ls_arready,
	input  logic [31:0]     ls_araddr,
	output logic            ls_rvalid,
	input  logic            ls_rready,
	output logic [31:0]     ls_rdata,
	output core_pkg::resp_e ls_rresp,
	input  logic            ls_awvalid,
	output logic            ls_awready,
	input  logic [31:0]     ls_awaddr,
	input  logic            ls_wvalid,
	output logic            ls_wready,
	input  logic [31:0]     ls_wdata,
	input  logic [3:0]      ls_wstrb,
	output logic            ls_bvalid,
	input  logic            ls_bready,
	output core_pkg::resp_e ls_bresp,
	output logic            mem_arvalid,
	input  logic            mem_arready,
	output logic [31:0]     mem_araddr,
	input  logic            mem_rvalid,
	output logic            mem_rready,
	input  logic [31:0]     mem_rdata,
	input  logic [1:0]      mem_rresp,
	output logic            mem_awvalid,
	input  logic            mem_awready,
	output logic [31:0]     mem_awaddr,
	output logic            mem_wvalid,
	input  logic            mem_wready,
	output logic [31:0]     mem_wdata,
	output logic [3:0]      mem_wstrb,
	input  logic            mem_bvalid,
	output logic            mem_bready,
	input  logic [1:0]      mem_bresp,
	output logic            tm_arvalid,
	input  logic            tm_arready,
	output logic [31:0]     tm_araddr,
	input  logic            tm_rvalid,
	output logic            tm_rready,
	input  logic [31:0]     tm_rdata,
	input  core_pkg::resp_e tm_rresp
);

	typedef enum logic [1:0] {NONE, FETCH, DATA} owner_e;

	owner_e owner, sel;
	logic   rd_tm, wr_tm, r_done, local_b;

	assign rd_tm = (ls_araddr & core_pkg::CLINT_MASK) == core_pkg::CLINT_BASE;
	assign wr_tm = (ls_awaddr & core_pkg::CLINT_MASK) == core_pkg::CLINT_BASE;

	// A free bus goes to the data side first and is held until the r beat
	always_comb begin
		sel = owner;
		if (owner == NONE) begin
			if (ls_arvalid)
				sel = DATA;
			else if (if_arvalid)
				sel = FETCH;
		end
	end

	assign mem_arvalid = (sel == FETCH && if_arvalid) || (sel == DATA && ls_arvalid && !rd_tm);
	assign mem_araddr  = sel == DATA ? ls_araddr : if_araddr;
	assign tm_arvalid  = sel == DATA && ls_arvalid && rd_tm;
	assign tm_araddr   = ls_araddr;
	assign if_arready  = sel == FETCH && mem_arready;
	assign ls_arready  = sel == DATA && (rd_tm ? tm_arready : mem_arready);

	assign if_rvalid  = owner == FETCH && mem_rvalid;
	assign if_rdata   = mem_rdata;
	assign ls_rvalid  = owner == DATA && (rd_tm ? tm_rvalid : mem_rvalid);
	assign ls_rdata   = rd_tm ? tm_rdata : mem_rdata;
	assign ls_rresp   = rd_tm ? tm_rresp : core_pkg::resp_e'(mem_rresp);
	assign mem_rready = (owner == FETCH && if_rready) || (owner == DATA && !rd_tm && ls_rready);
	assign tm_rready  = owner == DATA && rd_tm && ls_rready;
	assign r_done     = (if_rvalid && if_rready) || (ls_rvalid && ls_rready);

	always_ff @(posedge clock) begin
		if (rst || r_done)
			owner <= NONE;
		else
			owner <= sel;
	end

	// Timer writes are refused here and never leave the core
	assign mem_awvalid = ls_awvalid && !wr_tm;
	assign mem_awaddr  = ls_awaddr;
	assign mem_wvalid  = ls_wvalid && !wr_tm;
	assign mem_wdata   = ls_wdata;
	assign mem_wstrb   = ls_wstrb;
	assign ls_awready  = wr_tm || mem_awready;
	assign ls_wready   = wr_tm || mem_wready;
	assign ls_bvalid   = wr_tm ? local_b : mem_bvalid;
	assign ls_bresp    = wr_tm ? core_pkg::RESP_SLVERR : core_pkg::resp_e'(mem_bresp);
	assign mem_bready  = ls_bready && !wr_tm;

	always_ff @(posedge clock) begin
		if (rst)
			local_b <= 1'b0;
		else if (local_b && ls_bready)
			local_b <= 1'b0;
		else if (wr_tm && ls_awvalid && ls_wvalid)
			local_b <= 1'b1;
	end

	assert property (@(posedge clock) disable iff (rst)
		owner == NONE |-> !mem_rvalid && !tm_rvalid);

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
	input  logic        clock,
	input  logic        rst,
	output logic        if_arvalid,
	input  logic        if_arready,
	output logic [31:0] if_araddr,
	input  logic        if_rvalid,
	output logic        if_rready,
	input  logic [31:0] if_rdata,
	input  logic        wb_valid,
	input  logic [31:0] next_pc,
	output logic [31:0] inst,
	output logic [31:0] pc,
	output logic        id_valid,
	input  logic        id_ready
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT, HAND} state_e;

	state_e state;
	logic   boot;

	assign if_arvalid = state == REQ;
	assign if_araddr  = pc;
	assign if_rready  = state == WAIT;
	assign id_valid   = state == HAND;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
			boot  <= 1'b1;
			pc    <= core_pkg::RESET_PC;
		end else begin
			case (state)
				IDLE: begin
					// The first fetch after reset starts without a write-back
					if (boot || wb_valid) begin
						state <= REQ;
						boot  <= 1'b0;
					end
					if (wb_valid)
						pc <= next_pc;
				end
				REQ:
					if (if_arready)
						state <= WAIT;
				WAIT:
					if (if_rvalid) begin
						inst  <= if_rdata;
						state <= HAND;
					end
				HAND:
					if (id_ready)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (rst)
		if_arvalid && !if_arready |=> if_arvalid && $stable(if_araddr));

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
	input  logic          clock,
	input  logic          rst,
	input  logic [31:0]   inst,
	input  logic [31:0]   pc_in,
	input  logic          id_valid,
	output logic          id_ready,
	output logic [3:0]    rs1,
	output logic [3:0]    rs2,
	input  logic [31:0]   rdata1,
	input  logic [31:0]   rdata2,
	output core_pkg::op_e op,
	output logic [3:0]    rd,
	output logic [31:0]   src1,
	output logic [31:0]   src2,
	output logic [31:0]   imm,
	output logic [31:0]   pc,
	output logic          ex_valid,
	input  logic          ex_ready
);

	core_pkg::op_e base_op;
	logic [31:0]   dec_imm;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	logic          rd_bad, rs1_bad, rs2_bad, bad_reg;

	assign funct3  = inst[14:12];
	assign funct7  = inst[31:25];
	assign rs1     = inst[18:15];
	assign rs2     = inst[23:20];
	// RV32E has only x0 to x15, so bit 4 of a used register field is illegal
	assign rd_bad  = inst[11:7] >= 5'(core_pkg::REG_COUNT);
	assign rs1_bad = inst[19:15] >= 5'(core_pkg::REG_COUNT);
	assign rs2_bad = inst[24:20] >= 5'(core_pkg::REG_COUNT);

	always_comb begin
		base_op = core_pkg::OP_ILLEGAL;
		dec_imm = {{20{inst[31]}}, inst[31:20]};
		case (inst[6:0])
			core_pkg::OPC_OP_IMM:
				if (funct3 == 3'b000)
					base_op = core_pkg::OP_ADDI;
			core_pkg::OPC_OP:
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					base_op = core_pkg::OP_ADD;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000)
					base_op = core_pkg::OP_SUB;
			core_pkg::OPC_LUI: begin
				base_op = core_pkg::OP_LUI;
				dec_imm = {inst[31:12], 12'b0};
			end
			core_pkg::OPC_LOAD:
				if (funct3 == 3'b010)
					base_op = core_pkg::OP_LW;
			core_pkg::OPC_STORE: begin
				if (funct3 == 3'b010)
					base_op = core_pkg::OP_SW;
				dec_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			core_pkg::OPC_BRANCH: begin
				if (funct3 == 3'b000)
					base_op = core_pkg::OP_BEQ;
				else if (funct3 == 3'b001)
					base_op = core_pkg::OP_BNE;
				dec_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			core_pkg::OPC_JAL: begin
				base_op = core_pkg::OP_JAL;
				dec_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: ;
		endcase
	end

	always_comb begin
		case (base_op)
			core_pkg::OP_ADD, core_pkg::OP_SUB:
				bad_reg = rd_bad || rs1_bad || rs2_bad;
			core_pkg::OP_ADDI, core_pkg::OP_LW:
				bad_reg = rd_bad || rs1_bad;
			core_pkg::OP_SW, core_pkg::OP_BEQ, core_pkg::OP_BNE:
				bad_reg = rs1_bad || rs2_bad;
			core_pkg::OP_LUI, core_pkg::OP_JAL:
				bad_reg = rd_bad;
			default:
				bad_reg = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			id_ready <= 1'b0;
			ex_valid <= 1'b0;
		end else if (id_valid && id_ready) begin
			id_ready <= 1'b0;
			ex_valid <= 1'b1;
		end else if (ex_ready || !ex_valid) begin
			id_ready <= 1'b1;
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (id_valid && id_ready) begin
			op   <= bad_reg ? core_pkg::OP_ILLEGAL : base_op;
			rd   <= inst[10:7];
			src1 <= rdata1;
			src2 <= rdata2;
			imm  <= dec_imm;
			pc   <= pc_in;
		end
	end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
	input  logic          clock,
	input  logic          rst,
	input  core_pkg::op_e op_in,
	input  logic [3:0]    rd_in,
	input  logic [31:0]   src1,
	input  logic [31:0]   src2,
	input  logic [31:0]   imm,
	input  logic [31:0]   pc_in,
	input  logic          ex_valid,
	output logic          ex_ready,
	output core_pkg::op_e op,
	output logic [3:0]    rd,
	output logic [31:0]   result,
	output logic [31:0]   store_data,
	output logic          reg_wen,
	output logic [31:0]   next_pc,
	output logic          ls_valid,
	input  logic          ls_ready
);

	logic [31:0] alu, seq_pc, target;
	logic        wen, taken;

	assign seq_pc = pc_in + 32'd4;
	assign target = pc_in + imm;

	// ADDI, LW and SW all use rs1 plus the immediate
	always_comb begin
		alu   = src1 + imm;
		taken = 1'b0;
		wen   = rd_in != 4'd0;
		case (op_in)
			core_pkg::OP_ADD: alu = src1 + src2;
			core_pkg::OP_SUB: alu = src1 - src2;
			core_pkg::OP_LUI: alu = imm;
			core_pkg::OP_JAL: begin
				alu   = seq_pc;
				taken = 1'b1;
			end
			core_pkg::OP_BEQ: begin
				taken = src1 == src2;
				wen   = 1'b0;
			end
			core_pkg::OP_BNE: begin
				taken = src1 != src2;
				wen   = 1'b0;
			end
			core_pkg::OP_SW, core_pkg::OP_ILLEGAL: wen = 1'b0;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ex_ready <= 1'b0;
			ls_valid <= 1'b0;
		end else if (ex_valid && ex_ready) begin
			ex_ready <= 1'b0;
			ls_valid <= 1'b1;
		end else if (ls_ready || !ls_valid) begin
			ex_ready <= 1'b1;
			ls_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ex_valid && ex_ready) begin
			op         <= op_in;
			rd         <= rd_in;
			result     <= alu;
			store_data <= src2;
			reg_wen    <= wen;
			next_pc    <= taken ? target : seq_pc;
		end
	end

endmodule

//--- src/mem_unit.sv
`timescale 1ns/1ns

module mem_unit (
	input  logic            clock,
	input  logic            rst,
	input  core_pkg::op_e   op,
	input  logic [3:0]      rd_in,
	input  logic [31:0]     result,
	input  logic [31:0]     store_data,
	input  logic            reg_wen_in,
	input  logic            ls_valid,
	output logic            ls_ready,
	output logic            ls_arvalid,
	input  logic            ls_arready,
	output logic [31:0]     ls_araddr,
	input  logic            ls_rvalid,
	output logic            ls_rready,
	input  logic [31:0]     ls_rdata,
	input  core_pkg::resp_e ls_rresp,
	output logic            ls_awvalid,
	input  logic            ls_awready,
	output logic [31:0]     ls_awaddr,
	output logic            ls_wvalid,
	input  logic            ls_wready,
	output logic [31:0]     ls_wdata,
	output logic [3:0]      ls_wstrb,
	input  logic            ls_bvalid,
	output logic            ls_bready,
	input  core_pkg::resp_e ls_bresp,
	output logic [3:0]      wb_rd,
	output logic [31:0]     wb_data,
	output logic            wb_wen,
	output logic            wb_valid
);

	typedef enum logic [2:0] {IDLE, READ, RDATA, WRITE, BRESP, DONE} state_e;

	state_e      state;
	logic        aw_done, w_done, aw_hs, w_hs, wen_q;
	logic [31:0] addr, wdata_q;

	assign ls_arvalid = state == READ;
	assign ls_araddr  = addr;
	assign ls_rready  = state == RDATA;
	assign ls_awvalid = state == WRITE && !aw_done;
	assign ls_awaddr  = addr;
	assign ls_wvalid  = state == WRITE && !w_done;
	assign ls_wdata   = wdata_q;
	assign ls_wstrb   = 4'hf;
	assign ls_bready  = state == BRESP;
	assign aw_hs      = ls_awvalid && ls_awready;
	assign w_hs       = ls_wvalid && ls_wready;
	assign wb_valid   = state == DONE;
	assign wb_wen     = wb_valid && wen_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= IDLE;
			ls_ready <= 1'b0;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
		end else begin
			case (state)
				IDLE:
					if (!ls_ready) begin
						ls_ready <= 1'b1;
					end else if (ls_valid) begin
						ls_ready <= 1'b0;
						addr     <= result;
						wdata_q  <= store_data;
						wb_rd    <= rd_in;
						wb_data  <= result;
						wen_q    <= reg_wen_in;
						if (op == core_pkg::OP_LW)
							state <= READ;
						else if (op == core_pkg::OP_SW)
							state <= WRITE;
						else
							state <= DONE;
					end
				READ:
					if (ls_arready)
						state <= RDATA;
				RDATA:
					// An error response leaves the register file untouched
					if (ls_rvalid) begin
						wb_data <= ls_rdata;
						wen_q   <= wen_q && ls_rresp == core_pkg::RESP_OKAY;
						state   <= DONE;
					end
				WRITE: begin
					if (aw_hs)
						aw_done <= 1'b1;
					if (w_hs)
						w_done <= 1'b1;
					if ((aw_done || aw_hs) && (w_done || w_hs)) begin
						aw_done <= 1'b0;
						w_done  <= 1'b0;
						state   <= BRESP;
					end
				end
				BRESP:
					if (ls_bvalid) begin
						wen_q <= wen_q && ls_bresp == core_pkg::RESP_OKAY;
						state <= DONE;
					end
				DONE: begin
					ls_ready <= 1'b1;
					state    <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (rst)
		state == WRITE && (aw_done || ls_awready) && (w_done || ls_wready)
		|=> !ls_awvalid && !ls_wvalid);

endmodule

//--- src/core_top.sv
`timescale 1ns/1ns

module core_top (
	input  logic        clock,
	input  logic        rst,
	output logic        mem_arvalid,
	input  logic        mem_arready,
	output logic [31:0] mem_araddr,
	input  logic        mem_rvalid,
	output logic        mem_rready,
	input  logic [31:0] mem_rdata,
	input  logic [1:0]  mem_rresp,
	output logic        mem_awvalid,
	input  logic        mem_awready,
	output logic [31:0] mem_awaddr,
	output logic        mem_wvalid,
	input  logic        mem_wready,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wstrb,
	input  logic        mem_bvalid,
	output logic        mem_bready,
	input  logic [1:0]  mem_bresp
);

	logic            if_arvalid, if_arready, if_rvalid, if_rready;
	logic [31:0]     if_araddr, if_rdata;
	logic            ls_arvalid, ls_arready, ls_rvalid, ls_rready;
	logic            ls_awvalid, ls_awready, ls_wvalid, ls_wready, ls_bvalid, ls_bready;
	logic [31:0]     ls_araddr, ls_rdata, ls_awaddr, ls_wdata;
	logic [3:0]      ls_wstrb;
	core_pkg::resp_e ls_rresp, ls_bresp, tm_rresp;
	logic            tm_arvalid, tm_arready, tm_rvalid, tm_rready;
	logic [31:0]     tm_araddr, tm_rdata;
	logic            id_valid, id_ready, ex_valid, ex_ready, ls_valid, ls_ready;
	logic            reg_wen, wb_wen, wb_valid;
	logic [31:0]     inst, if_pc, id_pc, next_pc;
	logic [31:0]     rdata1, rdata2, src1, src2, imm, result, store_data, wb_data;
	logic [3:0]      rs1, rs2, id_rd, ex_rd, wb_rd;
	core_pkg::op_e   id_op, ex_op;

	fetch_unit u_fetch (.pc(if_pc), .*);

	decode_unit u_decode (.pc_in(if_pc), .op(id_op), .rd(id_rd), .pc(id_pc), .*);

	execute_unit u_execute (
		.op_in(id_op), .rd_in(id_rd), .pc_in(id_pc), .op(ex_op), .rd(ex_rd), .*
	);

	mem_unit u_mem (.op(ex_op), .rd_in(ex_rd), .reg_wen_in(reg_wen), .*);

	reg_file u_regs (
		.raddr1(rs1), .raddr2(rs2), .waddr(wb_rd), .wdata(wb_data), .wen(wb_wen), .*
	);

	bus_xbar u_xbar (.*);

	clint_timer u_clint (.*);

endmodule

//--- dv/tb_core.sv
`timescale 1ns/1ns

module tb_core;

	localparam logic [31:0] SEED           = 32'h59d2_4e31;
	localparam int          TIMEOUT_CYCLES = 5000;
	localparam logic [31:0] FILL_KEY       = 32'h5a5a_5a5a;
	localparam logic [31:0] DATA_ADDR      = 32'h8000_1000;
	localparam logic [31:0] RESULT_ADDR    = DATA_ADDR + 32'h100;
	localparam logic [31:0] LOADST_ADDR    = DATA_ADDR + 32'h104;
	localparam logic [31:0] TIME0_ADDR     = DATA_ADDR + 32'h108;
	localparam logic [31:0] TIME1_ADDR     = DATA_ADDR + 32'h10c;
	localparam logic [31:0] DONE_ADDR      = DATA_ADDR + 32'h110;
	localparam logic [31:0] CODE_END       = core_pkg::RESET_PC + 32'd96;
	localparam logic [31:0] BEQ_PC         = core_pkg::RESET_PC + 32'd80;
	localparam logic [31:0] BEQ_TARGET     = core_pkg::RESET_PC + 32'd88;
	// Link written by the JAL that leaves the loop
	localparam logic [31:0] LINK_ADDR      = core_pkg::RESET_PC + 32'd32;
	// Sum of 1 through 10
	localparam logic [31:0] SUM_EXPECT     = 32'd55;

	logic        clock = 1'b0;
	logic        rst;
	logic        mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic [31:0] mem_araddr, mem_rdata;
	logic [1:0]  mem_rresp;
	logic        mem_awvalid, mem_awready, mem_wvalid, mem_wready;
	logic [31:0] mem_awaddr, mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        mem_bvalid, mem_bready;
	logic [1:0]  mem_bresp;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] prev_araddr, prev_awaddr, prev_wdata, last_fetch, time0_q;
	logic [3:0]  prev_wstrb;
	logic        ar_hs, w_hs, code_read;
	logic        sum_seen, loadst_seen, time_seen, beq_seen, done_seen;
	int          errors, w_count, fetches, stalls, cycles;

	core_top UUT (.*);

	always #10 clock = ~clock;

	assign ar_hs     = mem_arvalid && mem_arready;
	assign w_hs      = mem_wvalid && mem_wready;
	assign code_read = mem_araddr >= core_pkg::RESET_PC && mem_araddr < CODE_END;

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [4:0] rd);
		return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] read_word(logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ FILL_KEY;
	endfunction

	task automatic put_code(int index, logic [31:0] word);
		mem[core_pkg::RESET_PC + 32'(index * 4)] = word;
	endtask

	task automatic load_program();
		put_code(0, u_type(20'h80001, 5'd1));
		put_code(1, i_type(12'd0, 5'd0, 3'b000, 5'd2, 7'b0010011));
		put_code(2, i_type(12'd10, 5'd0, 3'b000, 5'd3, 7'b0010011));
		put_code(3, i_type(12'd1, 5'd0, 3'b000, 5'd4, 7'b0010011));
		// Loop body adds the counter to the sum and counts down to zero
		put_code(4, r_type(7'b0000000, 5'd3, 5'd2, 5'd2));
		put_code(5, r_type(7'b0100000, 5'd4, 5'd3, 5'd3));
		put_code(6, b_type(13'h1ff8, 5'd0, 5'd3, 3'b001));
		put_code(7, j_type(21'd8, 5'd5));
		put_code(8, i_type(12'd0, 5'd0, 3'b000, 5'd2, 7'b0010011));
		put_code(9, s_type(12'h100, 5'd2, 5'd1));
		put_code(10, i_type(12'd0, 5'd1, 3'b010, 5'd6, 7'b0000011));
		put_code(11, i_type(12'd1, 5'd6, 3'b000, 5'd6, 7'b0010011));
		put_code(12, s_type(12'h104, 5'd6, 5'd1));
		// Two mtime low reads with a couple of instructions between them
		put_code(13, u_type(20'h02000, 5'd7));
		put_code(14, i_type(12'd0, 5'd7, 3'b010, 5'd8, 7'b0000011));
		put_code(15, i_type(12'd3, 5'd0, 3'b000, 5'd9, 7'b0010011));
		put_code(16, i_type(12'd1, 5'd9, 3'b000, 5'd9, 7'b0010011));
		put_code(17, i_type(12'd0, 5'd7, 3'b010, 5'd10, 7'b0000011));
		put_code(18, s_type(12'h108, 5'd8, 5'd1));
		put_code(19, s_type(12'h10c, 5'd10, 5'd1));
		put_code(20, b_type(13'd8, 5'd4, 5'd4, 3'b000));
		put_code(21, s_type(12'h100, 5'd0, 5'd1));
		put_code(22, s_type(12'h110, 5'd5, 5'd1));
		put_code(23, j_type(21'd0, 5'd0));
	endtask

	// The memory model decides all handshakes on the falling edge
	initial begin : bus_model
		int unsigned ar_wait, r_wait, aw_wait, w_wait, b_wait;
		logic        rd_busy, aw_got, w_got, b_sent;
		logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;
		logic [31:0] rd_addr, wr_addr, wr_data, ar_addr_q, aw_addr_q, w_data_q;

		void'($urandom(SEED));
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_rdata   = 32'd0;
		mem_rresp   = 2'b00;
		mem_awready = 1'b0;
		mem_wready  = 1'b0;
		mem_bvalid  = 1'b0;
		mem_bresp   = 2'b00;
		rd_busy     = 1'b0;
		aw_got      = 1'b0;
		w_got       = 1'b0;
		b_sent      = 1'b0;
		ar_fire     = 1'b0;
		r_fire      = 1'b0;
		aw_fire     = 1'b0;
		w_fire      = 1'b0;
		b_fire      = 1'b0;
		ar_wait     = $urandom % 4;
		aw_wait     = $urandom % 4;
		w_wait      = $urandom % 4;
		b_wait      = $urandom % 4;
		load_program();
		forever begin
			@(negedge clock);
			// Fire flags from the last falling edge completed on the rising edge since
			if (ar_fire) begin
				mem_arready = 1'b0;
				rd_busy     = 1'b1;
				rd_addr     = ar_addr_q;
				r_wait      = $urandom % 4;
				ar_wait     = $urandom % 4;
			end
			if (r_fire) begin
				mem_rvalid = 1'b0;
				rd_busy    = 1'b0;
			end
			if (aw_fire) begin
				mem_awready = 1'b0;
				aw_got      = 1'b1;
				wr_addr     = aw_addr_q;
				aw_wait     = $urandom % 4;
			end
			if (w_fire) begin
				mem_wready = 1'b0;
				w_got      = 1'b1;
				wr_data    = w_data_q;
				w_wait     = $urandom % 4;
			end
			if (b_fire) begin
				mem_bvalid = 1'b0;
				aw_got     = 1'b0;
				w_got      = 1'b0;
				b_sent     = 1'b0;
				b_wait     = $urandom % 4;
			end
			if (mem_arvalid && !mem_arready && !rd_busy) begin
				if (ar_wait == 0)
					mem_arready = 1'b1;
				else
					ar_wait--;
			end
			if (rd_busy && !mem_rvalid) begin
				if (r_wait == 0) begin
					mem_rvalid = 1'b1;
					mem_rdata  = read_word(rd_addr);
				end else begin
					r_wait--;
				end
			end
			if (mem_awvalid && !mem_awready && !aw_got) begin
				if (aw_wait == 0)
					mem_awready = 1'b1;
				else
					aw_wait--;
			end
			if (mem_wvalid && !mem_wready && !w_got) begin
				if (w_wait == 0)
					mem_wready = 1'b1;
				else
					w_wait--;
			end
			if (aw_got && w_got && !b_sent) begin
				if (b_wait == 0) begin
					mem[wr_addr] = wr_data;
					mem_bvalid   = 1'b1;
					b_sent       = 1'b1;
				end else begin
					b_wait--;
				end
			end
			// DUT outputs hold until the next rising edge, so these fire on it
			ar_fire   = mem_arvalid && mem_arready;
			ar_addr_q = mem_araddr;
			r_fire    = mem_rvalid && mem_rready;
			aw_fire   = mem_awvalid && mem_awready;
			aw_addr_q = mem_awaddr;
			w_fire    = mem_wvalid && mem_wready;
			w_data_q  = mem_wdata;
			b_fire    = mem_bvalid && mem_bready;
		end
	end

	always @(posedge clock) begin
		prev_araddr <= mem_araddr;
		prev_awaddr <= mem_awaddr;
		prev_wdata  <= mem_wdata;
		prev_wstrb  <= mem_wstrb;
		if (rst) begin
			last_fetch  <= 32'd0;
			time0_q     <= 32'd0;
			w_count     <= 0;
			fetches     <= 0;
			stalls      <= 0;
			sum_seen    <= 1'b0;
			loadst_seen <= 1'b0;
			time_seen   <= 1'b0;
			beq_seen    <= 1'b0;
			done_seen   <= 1'b0;
		end else begin
			if (w_hs) begin
				w_count <= w_count + 1;
				if (mem_awaddr == RESULT_ADDR)
					sum_seen <= 1'b1;
				if (mem_awaddr == LOADST_ADDR)
					loadst_seen <= 1'b1;
				if (mem_awaddr == TIME0_ADDR)
					time0_q <= mem_wdata;
				if (mem_awaddr == TIME1_ADDR)
					time_seen <= 1'b1;
				if (mem_awaddr == DONE_ADDR)
					done_seen <= 1'b1;
			end
			if (ar_hs && code_read) begin
				last_fetch <= mem_araddr;
				fetches    <= fetches + 1;
				if (last_fetch == BEQ_PC)
					beq_seen <= 1'b1;
			end
			if ((mem_arvalid && !mem_arready) || (mem_awvalid && !mem_awready) ||
					(mem_wvalid && !mem_wready))
				stalls <= stalls + 1;
		end
	end

	assert property (@(posedge clock) $past(rst) |->
			!mem_arvalid && !mem_awvalid && !mem_wvalid && !mem_rready && !mem_bready)
	else begin
		errors++;
		$display("ERROR reset outputs: arvalid %h awvalid %h wvalid %h rready %h bready %h",
			$sampled(mem_arvalid), $sampled(mem_awvalid), $sampled(mem_wvalid),
			$sampled(mem_rready), $sampled(mem_bready));
	end

	assert property (@(posedge clock) $fell(rst) |=>
			mem_arvalid && mem_araddr == core_pkg::RESET_PC)
	else begin
		errors++;
		$display("ERROR mem_araddr: expected %h, got %h with mem_arvalid %h",
			core_pkg::RESET_PC, $sampled(mem_araddr), $sampled(mem_arvalid));
	end

	assert property (@(posedge clock) disable iff (rst) mem_arvalid && !mem_arready |=>
			mem_arvalid && mem_araddr == prev_araddr)
	else begin
		errors++;
		$display("ERROR mem_araddr: changed from %h to %h while stalled",
			$sampled(prev_araddr), $sampled(mem_araddr));
	end

	assert property (@(posedge clock) disable iff (rst) mem_awvalid && !mem_awready |=>
			mem_awvalid && mem_awaddr == prev_awaddr)
	else begin
		errors++;
		$display("ERROR mem_awaddr: changed from %h to %h while stalled",
			$sampled(prev_awaddr), $sampled(mem_awaddr));
	end

	assert property (@(posedge clock) disable iff (rst) mem_wvalid && !mem_wready |=>
			mem_wvalid && mem_wdata == prev_wdata && mem_wstrb == prev_wstrb)
	else begin
		errors++;
		$display("ERROR mem_wdata/mem_wstrb: changed from %h/%h to %h/%h while stalled",
			$sampled(prev_wdata), $sampled(prev_wstrb), $sampled(mem_wdata),
			$sampled(mem_wstrb));
	end

	assert property (@(posedge clock) disable iff (rst)
			mem_arvalid |-> (mem_araddr & ~32'h7) != core_pkg::CLINT_BASE)
	else begin
		errors++;
		$display("ERROR mem_araddr: timer address %h reached the master port",
			$sampled(mem_araddr));
	end

	assert property (@(posedge clock) disable iff (rst) w_hs && w_count == 0 |->
			mem_awaddr == RESULT_ADDR && mem_wstrb == 4'hf)
	else begin
		errors++;
		$display("ERROR mem_awaddr/mem_wstrb: expected %h/f, got %h/%h on the first store",
			RESULT_ADDR, $sampled(mem_awaddr), $sampled(mem_wstrb));
	end

	assert property (@(posedge clock) disable iff (rst) w_hs && mem_awaddr == RESULT_ADDR |->
			mem_wdata == SUM_EXPECT)
	else begin
		errors++;
		$display("ERROR mem_wdata: expected %h, got %h", SUM_EXPECT, $sampled(mem_wdata));
	end

	assert property (@(posedge clock) disable iff (rst) w_hs && mem_awaddr == LOADST_ADDR |->
			mem_wdata == (DATA_ADDR ^ FILL_KEY) + 32'd1)
	else begin
		errors++;
		$display("ERROR mem_wdata: expected %h, got %h",
			(DATA_ADDR ^ FILL_KEY) + 32'd1, $sampled(mem_wdata));
	end

	assert property (@(posedge clock) disable iff (rst) w_hs && mem_awaddr == TIME1_ADDR |->
			mem_wdata > time0_q)
	else begin
		errors++;
		$display("ERROR mem_wdata: second mtime %h not above first %h",
			$sampled(mem_wdata), $sampled(time0_q));
	end

	assert property (@(posedge clock) disable iff (rst)
			ar_hs && code_read && last_fetch == BEQ_PC |-> mem_araddr == BEQ_TARGET)
	else begin
		errors++;
		$display("ERROR mem_araddr: expected %h after the branch, got %h",
			BEQ_TARGET, $sampled(mem_araddr));
	end

	assert property (@(posedge clock) disable iff (rst) w_hs && mem_awaddr == DONE_ADDR |->
			mem_wdata == LINK_ADDR)
	else begin
		errors++;
		$display("ERROR mem_wdata: expected %h, got %h", LINK_ADDR, $sampled(mem_wdata));
	end

	initial begin
		errors = 0;
		rst    = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst    = 1'b0;
		cycles = 0;
		while (!done_seen && cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		if (!done_seen) begin
			errors++;
			$display("Timeout after %0d cycles without the store to the done address", cycles);
		end
		if (!sum_seen) begin
			errors++;
			$display("The loop sum was never stored");
		end
		if (!loadst_seen) begin
			errors++;
			$display("The incremented load value was never stored");
		end
		if (!time_seen) begin
			errors++;
			$display("The second timer value was never stored");
		end
		if (!beq_seen) begin
			errors++;
			$display("No fetch followed the taken branch");
		end
		$display("Summary: %0d errors, %0d fetches, %0d stores, %0d stall cycles, %0d cycles",
			errors, fetches, w_count, stalls, cycles);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- list.f
src/core_pkg.sv
src/reg_file.sv
src/clint_timer.sv
src/bus_xbar.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/mem_unit.sv
src/core_top.sv
dv/tb_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_core
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The log search decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
